// File: hdl/psg_config.svh
`ifndef PSG_CONFIG_SVH
`define PSG_CONFIG_SVH

// ============================================================
// engine size
// ============================================================

// number of wave-table channels sharing the read port
`define PSG_CHANNELS 8
// bits needed to name one channel
`define PSG_CHAN_W 3

// ============================================================
// memory and sample format
// ============================================================

// memory word address and data widths
`define PSG_ADDR_W 16
`define PSG_DATA_W 16
// width of one decoded and scaled sample
`define PSG_SAMPLE_W 16

// phase is a 16.8 fixed point value, integer part is the sample index
`define PSG_FRAC_W 8
`define PSG_PHASE_W 24

// eight signed 16-bit samples need three extra bits of headroom
`define PSG_MIX_W 19

`endif

// File: hdl/psgBusPkg.sv
`include "psg_config.svh"

// ============================================================
// shared memory read port types
// ============================================================

package psgBusPkg;

	// one read request carries just the word address
	typedef struct packed {
		logic [`PSG_ADDR_W-1:0] addr;
	} psgMemReq;

	// one read response carries the data word that was addressed
	typedef struct packed {
		logic [`PSG_DATA_W-1:0] data;
	} psgMemRsp;

	// owner of the read port as decided by the arbiter
	// valid low means nobody holds the port and chan is meaningless
	typedef struct packed {
		logic valid;
		logic [`PSG_CHAN_W-1:0] chan;
	} psgGrant;

endpackage

// File: hdl/psgVoicePkg.sv
`include "psg_config.svh"

// ============================================================
// channel configuration and sample word types
// ============================================================

package psgVoicePkg;

	// how a memory word is split into samples
	typedef enum logic {
		sampleMode8 = 1'b0,
		sampleMode16 = 1'b1
	} psgSampleMode;

	// one configuration write, chan selects the target channel
	// step is the 8.8 phase increment added on every tick
	typedef struct packed {
		logic [`PSG_CHAN_W-1:0] chan;
		logic enable;
		psgSampleMode mode;
		logic [`PSG_ADDR_W-1:0] base;
		logic [15:0] length;
		logic [15:0] step;
		logic [3:0] volume;
	} psgChanCfg;

	// two packed 8-bit samples, the even index sits in the low byte
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} psgBytePair;

	// the same memory word read as one 16-bit sample or as two 8-bit ones
	typedef union packed {
		logic [`PSG_DATA_W-1:0] word;
		psgBytePair bytes;
	} psgSampleWord;

endpackage

// File: hdl/psgBusArb.sv
`include "psg_config.svh"

// fixed-priority arbiter for the shared memory read port
// the lowest requesting channel index always wins a new decision
module psgBusArb (
	input logic clk,
	input logic rst,
	input logic [`PSG_CHANNELS-1:0] req,
	input logic done,
	output psgBusPkg::psgGrant grant
);

	// requests that may take part in the next decision
	logic [`PSG_CHANNELS-1:0] reqMask;
	// a decision is due on an idle port or when the owner finishes
	logic decide;
	psgBusPkg::psgGrant nextGrant;

	// ============================================================
	// priority pick
	// ============================================================

	always_comb begin
		reqMask = req;
		// the owner still shows req during its done cycle,
		// it drops it on the same edge, so leave it out here
		if (done && grant.valid) begin
			reqMask[grant.chan] = 1'b0;
		end
		nextGrant = '0;
		// walk from the top down so the lowest index is written last
		for (int i = `PSG_CHANNELS - 1; i >= 0; i--) begin
			if (reqMask[i]) begin
				nextGrant.valid = 1'b1;
				nextGrant.chan = `PSG_CHAN_W'(i);
			end
		end
	end

	assign decide = !grant.valid || done;

	// ============================================================
	// grant register
	// ============================================================

	// the owner is held until done, with no requester the grant falls invalid
	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= '0;
		end else if (decide) begin
			grant <= nextGrant;
		end
	end

	// ============================================================
	// checks
	// ============================================================

	// the owner keeps the port for the whole transfer on the bus master
	assert property (@(posedge clk) disable iff (rst)
		(grant.valid && !done) |=> $stable(grant));

	// a grant only ever points at a channel that still wants the port
	assert property (@(posedge clk) disable iff (rst)
		grant.valid |-> req[grant.chan]);

endmodule

// File: hdl/psgWaveChannel.sv
`include "psg_config.svh"

// one wave-table channel
// keeps its configuration and phase, asks for a sample word on every tick
// and turns the returned word into a scaled sample
module psgWaveChannel (
	input logic clk,
	input logic rst,
	input logic cfgWrite,
	input psgVoicePkg::psgChanCfg cfg,
	input logic tick,
	input logic granted,
	input logic rspValid,
	input psgBusPkg::psgMemRsp rsp,
	output logic req,
	output logic [`PSG_ADDR_W-1:0] addr,
	output logic signed [`PSG_SAMPLE_W-1:0] sample
);

	psgVoicePkg::psgChanCfg cfgReg;
	// 16.8 phase whose integer part indexes the sample table
	logic [`PSG_PHASE_W-1:0] phase;
	logic [`PSG_PHASE_W-1:0] phaseStep;
	logic [`PSG_PHASE_W-1:0] phaseNext;
	logic [`PSG_PHASE_W-`PSG_FRAC_W-1:0] index;
	psgVoicePkg::psgSampleWord rspWord;
	logic signed [`PSG_SAMPLE_W-1:0] raw;
	// signed 16 by unsigned 4 product with one guard bit on top
	logic signed [`PSG_SAMPLE_W+4:0] scaled;
	logic signed [`PSG_SAMPLE_W-1:0] sampleReg;
	// our response is on the port this cycle
	logic take;

	// ============================================================
	// address
	// ============================================================

	assign index = phase[`PSG_PHASE_W-1:`PSG_FRAC_W];

	// two 8-bit samples share one word, so the word index is halved
	always_comb begin
		if (cfgReg.mode == psgVoicePkg::sampleMode16) begin
			addr = cfgReg.base + index;
		end else begin
			addr = cfgReg.base + (index >> 1);
		end
	end

	// ============================================================
	// decode and scale
	// ============================================================

	assign take = granted && rspValid;

	always_comb begin
		rspWord.word = rsp.data;
		if (cfgReg.mode == psgVoicePkg::sampleMode16) begin
			raw = rspWord.word;
		end else if (index[0]) begin
			// an odd index lives in the high byte and lands on the sample msb
			raw = {rspWord.bytes.hi, 8'h00};
		end else begin
			raw = {rspWord.bytes.lo, 8'h00};
		end
		// volume 15 is just under unity gain and 0 mutes
		scaled = raw * $signed({1'b0, cfgReg.volume});
	end

	// ============================================================
	// phase advance with wrap at the table length
	// ============================================================

	always_comb begin
		phaseStep = phase + `PSG_PHASE_W'(cfgReg.step);
		phaseNext = phaseStep;
		if (phaseStep[`PSG_PHASE_W-1:`PSG_FRAC_W] >= cfgReg.length) begin
			phaseNext = phaseStep - {cfgReg.length, {`PSG_FRAC_W{1'b0}}};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cfgReg <= '0;
			phase <= '0;
			req <= 1'b0;
		end else begin
			if (cfgWrite) begin
				cfgReg <= cfg;
				phase <= '0;
			end else if (take) begin
				phase <= phaseNext;
			end
			// the answer clears the request on the edge where done is seen
			if (take) begin
				req <= 1'b0;
			end else if (tick && cfgReg.enable) begin
				req <= 1'b1;
			end
		end
	end

	// a configuration write clears the payload of the last answered request
	always_ff @(posedge clk) begin
		if (cfgWrite) begin
			sampleReg <= '0;
		end else if (take) begin
			sampleReg <= scaled[`PSG_SAMPLE_W+3:4];
		end
	end

	assign sample = cfgReg.enable ? sampleReg : '0;

	// the top only passes a tick once every earlier request is answered
	assert property (@(posedge clk) disable iff (rst)
		(tick && cfgReg.enable) |-> !req);

endmodule

// File: hdl/psgBusMaster.sv
`include "psg_config.svh"

// drives the shared memory read port for whichever channel holds the grant
// and marks the returning word with the channel it belongs to
module psgBusMaster (
	input logic clk,
	input logic rst,
	input psgBusPkg::psgGrant grant,
	output logic memReqValid,
	input logic memReqReady,
	output psgBusPkg::psgMemReq memReq,
	input logic memRspValid,
	input psgBusPkg::psgMemRsp memRsp,
	input logic [`PSG_CHANNELS-1:0][`PSG_ADDR_W-1:0] addrs,
	output logic done,
	output logic [`PSG_CHAN_W-1:0] rspChan
);

	// ============================================================
	// read FSM
	// ============================================================

	// idle waits for a grant, request holds the address until the memory
	// accepts it, wait holds until the single response comes back
	typedef enum logic [1:0] {
		stIdle,
		stRequest,
		stWait
	} masterState;

	masterState state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: begin
					// after done the arbiter has already moved on,
					// so a valid grant seen here is always a new one
					if (grant.valid) begin
						state <= stRequest;
					end
				end
				stRequest: begin
					if (memReqReady) begin
						state <= stWait;
					end
				end
				stWait: begin
					if (memRspValid) begin
						state <= stIdle;
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	// address and owner are captured once and held through the transfer
	always_ff @(posedge clk) begin
		if (state == stIdle && grant.valid) begin
			memReq.addr <= addrs[grant.chan];
			rspChan <= grant.chan;
		end
	end

	assign memReqValid = (state == stRequest);
	// done is the response strobe itself, the latency is set by the memory
	assign done = (state == stWait) && memRspValid;

	// ============================================================
	// checks
	// ============================================================

	// one outstanding read, so a response outside the wait state is stray
	assert property (@(posedge clk) disable iff (rst)
		(state != stWait) |-> !memRspValid);

	// the memory returns defined data along with every response
	assert property (@(posedge clk) disable iff (rst)
		memRspValid |-> !$isunknown(memRsp));

endmodule

// File: hdl/psgMixer.sv
`include "psg_config.svh"

// adds the scaled channel samples into one output frame
// the frame is held on the output until the consumer takes it
module psgMixer (
	input logic clk,
	input logic rst,
	input logic frameDone,
	// one signed sample per channel
	input logic [`PSG_CHANNELS-1:0][`PSG_SAMPLE_W-1:0] samples,
	output logic mixValid,
	input logic mixReady,
	output logic signed [`PSG_MIX_W-1:0] mix
);

	logic signed [`PSG_MIX_W-1:0] sum;

	// each sample is sign extended to the mix width before adding
	always_comb begin
		sum = '0;
		for (int i = 0; i < `PSG_CHANNELS; i++) begin
			sum = sum + $signed(samples[i]);
		end
	end

	// ============================================================
	// output frame register
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			mixValid <= 1'b0;
		end else if (frameDone) begin
			mixValid <= 1'b1;
		end else if (mixReady) begin
			mixValid <= 1'b0;
		end
	end

	// the top holds off new ticks while a frame waits, so frameDone
	// never lands on a frame that has not been taken
	always_ff @(posedge clk) begin
		if (frameDone) begin
			mix <= sum;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(mixValid && !mixReady) |=> (mixValid && $stable(mix)));

endmodule

// File: hdl/psgWaveFetch.sv
`include "psg_config.svh"

// top of the wave-table fetch engine
// one tick fetches one sample per enabled channel and yields one mixed frame
module psgWaveFetch (
	input logic clk,
	input logic rst,
	input logic cfgValid,
	output logic cfgReady,
	input psgVoicePkg::psgChanCfg cfg,
	input logic tickValid,
	output logic tickReady,
	output logic memReqValid,
	input logic memReqReady,
	output psgBusPkg::psgMemReq memReq,
	input logic memRspValid,
	input psgBusPkg::psgMemRsp memRsp,
	output logic mixValid,
	input logic mixReady,
	output logic signed [`PSG_MIX_W-1:0] mix
);

	logic [`PSG_CHANNELS-1:0] req;
	logic [`PSG_CHANNELS-1:0] cfgWrite;
	logic [`PSG_CHANNELS-1:0] granted;
	logic [`PSG_CHANNELS-1:0] rspValid;
	logic [`PSG_CHANNELS-1:0][`PSG_ADDR_W-1:0] addrs;
	logic [`PSG_CHANNELS-1:0][`PSG_SAMPLE_W-1:0] samples;
	psgBusPkg::psgGrant grant;
	logic done;
	logic [`PSG_CHAN_W-1:0] rspChan;
	// a tick was accepted and its frame is not yet summed
	logic inFlight;
	logic tickTake;
	logic frameDone;

	// ============================================================
	// tick control
	// ============================================================

	// idle means no fetch under way and no frame waiting at the output
	assign tickReady = !(inFlight || mixValid);
	assign cfgReady = tickReady;
	assign tickTake = tickValid && tickReady;
	// with every request answered the channel samples are final
	assign frameDone = inFlight && !(|req);

	always_ff @(posedge clk) begin
		if (rst) begin
			inFlight <= 1'b0;
		end else if (tickTake) begin
			inFlight <= 1'b1;
		end else if (frameDone) begin
			inFlight <= 1'b0;
		end
	end

	// ============================================================
	// channels
	// ============================================================

	for (genvar i = 0; i < `PSG_CHANNELS; i++) begin : genChan
		// cfg.chan picks the one channel a write lands in
		assign cfgWrite[i] = cfgValid && cfgReady && (cfg.chan == `PSG_CHAN_W'(i));
		assign granted[i] = grant.valid && (grant.chan == `PSG_CHAN_W'(i));
		assign rspValid[i] = done && (rspChan == `PSG_CHAN_W'(i));

		psgWaveChannel uChan (
			.clk(clk),
			.rst(rst),
			.cfgWrite(cfgWrite[i]),
			.cfg(cfg),
			.tick(tickTake),
			.granted(granted[i]),
			.rspValid(rspValid[i]),
			.rsp(memRsp),
			.req(req[i]),
			.addr(addrs[i]),
			.sample(samples[i])
		);
	end

	// ============================================================
	// shared port and mix
	// ============================================================

	psgBusArb uArb (
		.clk(clk),
		.rst(rst),
		.req(req),
		.done(done),
		.grant(grant)
	);

	psgBusMaster uMaster (
		.clk(clk),
		.rst(rst),
		.grant(grant),
		.memReqValid(memReqValid),
		.memReqReady(memReqReady),
		.memReq(memReq),
		.memRspValid(memRspValid),
		.memRsp(memRsp),
		.addrs(addrs),
		.done(done),
		.rspChan(rspChan)
	);

	psgMixer uMixer (
		.clk(clk),
		.rst(rst),
		.frameDone(frameDone),
		.samples(samples),
		.mixValid(mixValid),
		.mixReady(mixReady),
		.mix(mix)
	);

endmodule

// File: verif/psgWaveFetchTb.sv
`include "psg_config.svh"

// testbench for the wave-table fetch engine
// a reference model predicts every memory address and every mixed frame
module psgWaveFetchTb;
	timeunit 1ns;
	timeprecision 100ps;

	// longest memory response delay in cycles
	localparam int MAX_DLY = 5;
	localparam int TOTAL_TICKS = 1 + 50 + 40 + 40 + 200 + 60;
	// each request costs handshake, arbitration and the random memory delay
	localparam longint WATCHDOG_NS =
		longint'(TOTAL_TICKS) * `PSG_CHANNELS * (MAX_DLY + 10) * 10 + 50000;

	logic clk;
	logic rst;
	logic cfgValid;
	logic cfgReady;
	psgVoicePkg::psgChanCfg cfg;
	logic tickValid;
	logic tickReady;
	logic memReqValid;
	logic memReqReady;
	psgBusPkg::psgMemReq memReq;
	logic memRspValid;
	psgBusPkg::psgMemRsp memRsp;
	logic mixValid;
	logic mixReady;
	logic signed [`PSG_MIX_W-1:0] mix;

	// model state with one entry per channel
	psgVoicePkg::psgChanCfg mCfg [`PSG_CHANNELS];
	logic [`PSG_PHASE_W-1:0] mPhase [`PSG_CHANNELS];
	// what the DUT must put on memReq and on mix in order of appearance
	logic [`PSG_ADDR_W-1:0] expAddr [$];
	logic signed [`PSG_MIX_W-1:0] expFrames [$];

	string testName;
	int valueErrors;
	int otherErrors;
	int ticksSent;
	int framesTaken;
	bit mixRandom;

	psgWaveFetch uut (
		.clk(clk),
		.rst(rst),
		.cfgValid(cfgValid),
		.cfgReady(cfgReady),
		.cfg(cfg),
		.tickValid(tickValid),
		.tickReady(tickReady),
		.memReqValid(memReqValid),
		.memReqReady(memReqReady),
		.memReq(memReq),
		.memRspValid(memRspValid),
		.memRsp(memRsp),
		.mixValid(mixValid),
		.mixReady(mixReady),
		.mix(mix)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ============================================================
	// helpers and reference model
	// ============================================================

	// memory contents where every address bit changes the word
	function automatic logic [15:0] memHash(input logic [15:0] a);
		return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'h5a3c;
	endfunction

	task automatic checkValue(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			valueErrors++;
			$display("ERR %s %s: expected %0d, actual %0d", testName, what, expected, actual);
		end
	endtask

	function automatic psgVoicePkg::psgChanCfg makeCfg(input int chan, input bit enable,
			input bit mode16, input int base, input int length, input int step, input int vol);
		psgVoicePkg::psgChanCfg c;
		c.chan = `PSG_CHAN_W'(chan);
		c.enable = enable;
		c.mode = mode16 ? psgVoicePkg::sampleMode16 : psgVoicePkg::sampleMode8;
		c.base = 16'(base);
		c.length = 16'(length);
		c.step = 16'(step);
		c.volume = 4'(vol);
		return c;
	endfunction

	// one model tick pushes the addresses in channel order and then the frame sum
	task automatic modelTick();
		logic [15:0] idx;
		logic [15:0] a;
		logic [15:0] w;
		logic signed [15:0] raw;
		logic [`PSG_PHASE_W-1:0] next;
		int prod;
		int sum;
		sum = 0;
		for (int ch = 0; ch < `PSG_CHANNELS; ch++) begin
			if (mCfg[ch].enable) begin
				idx = mPhase[ch][`PSG_PHASE_W-1:`PSG_FRAC_W];
				if (mCfg[ch].mode == psgVoicePkg::sampleMode16) begin
					a = mCfg[ch].base + idx;
				end else begin
					a = mCfg[ch].base + (idx >> 1);
				end
				expAddr.push_back(a);
				w = memHash(a);
				// 8-bit samples land on the upper byte of the 16-bit sample
				if (mCfg[ch].mode == psgVoicePkg::sampleMode16) begin
					raw = w;
				end else if (idx[0]) begin
					raw = {w[15:8], 8'h00};
				end else begin
					raw = {w[7:0], 8'h00};
				end
				prod = int'(raw) * int'(mCfg[ch].volume);
				sum += int'($signed(16'(prod >>> 4)));
				next = mPhase[ch] + `PSG_PHASE_W'(mCfg[ch].step);
				if (next[`PSG_PHASE_W-1:`PSG_FRAC_W] >= mCfg[ch].length) begin
					next = next - {mCfg[ch].length, 8'h00};
				end
				mPhase[ch] = next;
			end
		end
		expFrames.push_back(`PSG_MIX_W'(sum));
	endtask

	// all these tasks start and end 1 ns after a rising edge
	task automatic writeCfg(input psgVoicePkg::psgChanCfg c);
		cfgValid = 1'b1;
		cfg = c;
		@(negedge clk);
		while (!cfgReady) @(negedge clk);
		mCfg[c.chan] = c;
		mPhase[c.chan] = '0;
		@(posedge clk);
		#1;
		cfgValid = 1'b0;
	endtask

	task automatic sendTick();
		tickValid = 1'b1;
		@(negedge clk);
		while (!tickReady) @(negedge clk);
		modelTick();
		ticksSent++;
		@(posedge clk);
		#1;
		tickValid = 1'b0;
	endtask

	task automatic drainFrames();
		while (expFrames.size() != 0 || expAddr.size() != 0) @(negedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic runTicks(input int n);
		repeat (n) sendTick();
		drainFrames();
	endtask

	task automatic disableAll();
		for (int ch = 0; ch < `PSG_CHANNELS; ch++) begin
			writeCfg(makeCfg(ch, 1'b0, 1'b0, 0, 1, 0, 0));
		end
	endtask

	// ============================================================
	// memory responder
	// ============================================================

	// accepts one read and checks its address before answering after a random delay
	initial begin
		int dly;
		logic [15:0] a;
		forever begin
			@(negedge clk);
			if (memReqValid && memReqReady) begin
				a = memReq.addr;
				assert (expAddr.size() > 0) else begin
					otherErrors++;
					$display("%s: memory read issued that no channel should make", testName);
				end
				if (expAddr.size() > 0) begin
					checkValue("address", int'(expAddr.pop_front()), int'(a));
				end
				dly = $urandom_range(0, MAX_DLY);
				@(posedge clk);
				#1;
				repeat (dly) begin
					memReqReady = ($urandom % 4) != 0;
					@(posedge clk);
					#1;
				end
				memRspValid = 1'b1;
				memRsp.data = memHash(a);
				@(posedge clk);
				#1;
				memRspValid = 1'b0;
				memRsp.data = '0;
			end else begin
				@(posedge clk);
				#1;
				memReqReady = ($urandom % 4) != 0;
			end
		end
	end

	// ============================================================
	// frame consumer
	// ============================================================

	initial begin
		bit holding;
		logic signed [`PSG_MIX_W-1:0] heldMix;
		holding = 1'b0;
		forever begin
			@(negedge clk);
			if (mixValid) begin
				assert (!tickReady) else begin
					otherErrors++;
					$display("%s: tickReady is high while a frame waits", testName);
				end
			end
			if (holding) begin
				assert (mixValid && mix == heldMix) else begin
					otherErrors++;
					$display("%s: waiting frame changed or vanished before it was taken",
						testName);
				end
			end
			if (mixValid && mixReady) begin
				holding = 1'b0;
				framesTaken++;
				assert (expFrames.size() > 0) else begin
					otherErrors++;
					$display("%s: frame delivered without a pending tick", testName);
				end
				if (expFrames.size() > 0) begin
					checkValue("frame", int'(expFrames.pop_front()), int'(mix));
				end
			end else begin
				holding = mixValid;
				heldMix = mix;
			end
			@(posedge clk);
			#1;
			mixReady = mixRandom ? ($urandom % 2) != 0 : 1'b1;
		end
	end

	// ============================================================
	// watchdog
	// ============================================================

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("errors: value %0d, other %0d", valueErrors, otherErrors);
		$display("CHECKS FAILED");
		$finish;
	end

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		int len;
		void'($urandom(32'h74c2_bcbf));
		valueErrors = 0;
		otherErrors = 0;
		ticksSent = 0;
		framesTaken = 0;
		mixRandom = 1'b0;
		rst = 1'b1;
		cfgValid = 1'b0;
		cfg = '0;
		tickValid = 1'b0;
		memReqReady = 1'b0;
		memRspValid = 1'b0;
		memRsp = '0;
		mixReady = 1'b1;
		for (int ch = 0; ch < `PSG_CHANNELS; ch++) begin
			mCfg[ch] = '0;
			mPhase[ch] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// idle outputs after reset and then a tick with every channel off
		testName = "reset";
		@(negedge clk);
		checkValue("memReqValid", 0, int'(memReqValid));
		checkValue("mixValid", 0, int'(mixValid));
		checkValue("tickReady", 1, int'(tickReady));
		checkValue("cfgReady", 1, int'(cfgReady));
		@(posedge clk);
		#1;
		testName = "zeroFrame";
		runTicks(1);

		testName = "mode16";
		len = $urandom_range(2, 200);
		writeCfg(makeCfg($urandom_range(0, 7), 1'b1, 1'b1, $urandom, len,
			$urandom_range(1, len * 256 - 1), $urandom_range(1, 15)));
		runTicks(50);

		// whole-sample steps make the index alternate between even and odd
		testName = "mode8";
		disableAll();
		writeCfg(makeCfg($urandom_range(0, 7), 1'b1, 1'b0, $urandom,
			$urandom_range(4, 64), 16'h0100, $urandom_range(8, 15)));
		runTicks(40);

		testName = "multiChannel";
		for (int ch = 0; ch < `PSG_CHANNELS; ch++) begin
			len = $urandom_range(2, 500);
			writeCfg(makeCfg(ch, (($urandom % 4) != 0) || ch == 3 || ch == 6,
				$urandom % 2, $urandom, len, $urandom_range(1, len * 256 - 1),
				$urandom_range(0, 15)));
		end
		runTicks(40);

		// short tables with fractional steps wrap often
		testName = "phaseWrap";
		for (int ch = 0; ch < `PSG_CHANNELS; ch++) begin
			len = $urandom_range(1, 8);
			writeCfg(makeCfg(ch, 1'b1, $urandom % 2, $urandom, len,
				$urandom_range(16, len * 256 - 1), $urandom_range(1, 15)));
		end
		runTicks(200);

		testName = "backPressure";
		mixRandom = 1'b1;
		for (int ch = 0; ch < `PSG_CHANNELS; ch++) begin
			len = $urandom_range(2, 100);
			writeCfg(makeCfg(ch, ($urandom % 2) != 0 || ch == 0, $urandom % 2, $urandom,
				len, $urandom_range(1, len * 256 - 1), $urandom_range(1, 15)));
		end
		runTicks(60);
		mixRandom = 1'b0;
		repeat (4) @(posedge clk);

		// each tick must have produced exactly one frame
		assert (framesTaken == ticksSent) else begin
			otherErrors++;
			$display("frame count mismatch: %0d ticks sent, %0d frames taken",
				ticksSent, framesTaken);
		end
		$display("errors: value %0d, other %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+hdl
hdl/psgBusPkg.sv
hdl/psgVoicePkg.sv
hdl/psgBusArb.sv
hdl/psgWaveChannel.sv
hdl/psgBusMaster.sv
hdl/psgMixer.sv
hdl/psgWaveFetch.sv
verif/psgWaveFetchTb.sv

// File: Bender.yml
package:
  name: psg_wave_fetch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/psgBusPkg.sv
      - hdl/psgVoicePkg.sv
      - hdl/psgBusArb.sv
      - hdl/psgWaveChannel.sv
      - hdl/psgBusMaster.sv
      - hdl/psgMixer.sv
      - hdl/psgWaveFetch.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/psgWaveFetchTb.sv
